//--- source/analog_defs.svh
`ifndef ANALOG_DEFS_SVH
`define ANALOG_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// data path dimensions
//////////////////////////////////////////////////////////////////////

// number of analog channels, ADC and DAC alike
`define ANALOG_CHN      2
// raw converter word, taken from ADC pins 15..2
`define ANALOG_RAW_W    14
// signed sample width
`define ANALOG_SMP_W    14
// signed gain, 14 fraction bits
`define ANALOG_MUL_W    16
// gain of 1.0
`define ANALOG_UNITY    16'sd16384

//////////////////////////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////////////////////////

`define ANALOG_REG_AW   3
// loopback control bits
`define ANALOG_ADDR_CTRL 3'd0
// ADC calibration per channel
`define ANALOG_ADDR_ADC0 3'd1
`define ANALOG_ADDR_ADC1 3'd2
// DAC calibration per channel
`define ANALOG_ADDR_DAC0 3'd3
`define ANALOG_ADDR_DAC1 3'd4

`endif

//--- source/sample_pkg.sv
`include "analog_defs.svh"

package sample_pkg;

  //////////////////////////////////////////////////////////////////////
  // samples and calibration
  //////////////////////////////////////////////////////////////////////

  // one signed sample, two's complement
  typedef logic signed [`ANALOG_SMP_W-1:0] sample_t;

  // gain and offset for one channel
  typedef struct packed {
    // gain, 1.0 is ANALOG_UNITY
    logic signed [`ANALOG_MUL_W-1:0] mul;
    // offset, added after scaling
    sample_t                         sum;
  } calib_t;

  // one pair per channel
  typedef calib_t [`ANALOG_CHN-1:0] calib_set_t;

  //////////////////////////////////////////////////////////////////////
  // sample stream between modules
  //////////////////////////////////////////////////////////////////////

  // data only meaningful while vld is high, no back-pressure
  typedef struct packed {
    logic                       vld;
    sample_t [`ANALOG_CHN-1:0]  smp;
  } smp_bus_t;

endpackage

//--- source/regs_pkg.sv
`include "analog_defs.svh"

package regs_pkg;

  //////////////////////////////////////////////////////////////////////
  // register access
  //////////////////////////////////////////////////////////////////////

  // single cycle write strobe, read is combinational on addr
  typedef struct packed {
    logic                      wr;
    logic [`ANALOG_REG_AW-1:0] addr;
    logic [31:0]               wdata;
  } reg_req_t;

  //////////////////////////////////////////////////////////////////////
  // register word views
  //////////////////////////////////////////////////////////////////////

  // calibration word: gain on top, offset at the bottom
  typedef struct packed {
    logic [`ANALOG_MUL_W-1:0]                   mul;
    logic [32-`ANALOG_MUL_W-`ANALOG_SMP_W-1:0]  rsv;
    logic [`ANALOG_SMP_W-1:0]                   sum;
  } calib_word_t;

  // control word: loopback enables in the low bits
  typedef struct packed {
    logic [32-`ANALOG_CHN-1:0] rsv;
    logic [`ANALOG_CHN-1:0]    loop;
  } ctrl_word_t;

  // same 32 bits, view picked by address
  typedef union packed {
    calib_word_t calib;
    ctrl_word_t  ctrl;
  } reg_word_u;

endpackage

//--- source/calib_regs.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module calib_regs (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  input  regs_pkg::reg_req_t     req_i,
  output logic [31:0]            rdata_o,
  output logic [`ANALOG_CHN-1:0] loop_o,
  output sample_pkg::calib_set_t adc_cal_o,
  output sample_pkg::calib_set_t dac_cal_o
);

  localparam int unsigned CHN = `ANALOG_CHN;

  // unity gain, no offset
  localparam sample_pkg::calib_t CAL_RST = '{mul: `ANALOG_UNITY, sum: '0};

  // write data seen through the union
  regs_pkg::reg_word_u wr_word;
  // calibration pair taken from the calib view
  sample_pkg::calib_t  wr_cal;
  // readback word, rebuilt per address
  regs_pkg::reg_word_u rd_word;

  // pack one calibration pair into a bus word, reserved bits zero
  function automatic regs_pkg::reg_word_u calib_word(input sample_pkg::calib_t cal);
    regs_pkg::reg_word_u w;
    w           = '0;
    w.calib.mul = cal.mul;
    w.calib.sum = cal.sum;
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  assign wr_word = req_i.wdata;
  assign wr_cal  = '{mul: wr_word.calib.mul, sum: wr_word.calib.sum};

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_o    <= '0;
      adc_cal_o <= {CHN{CAL_RST}};
      dac_cal_o <= {CHN{CAL_RST}};
    end else if (req_i.wr) begin
      // unknown addresses drop the write
      case (req_i.addr)
        `ANALOG_ADDR_CTRL: loop_o       <= wr_word.ctrl.loop;
        `ANALOG_ADDR_ADC0: adc_cal_o[0] <= wr_cal;
        `ANALOG_ADDR_ADC1: adc_cal_o[1] <= wr_cal;
        `ANALOG_ADDR_DAC0: dac_cal_o[0] <= wr_cal;
        `ANALOG_ADDR_DAC1: dac_cal_o[1] <= wr_cal;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  // follows addr directly, unknown addresses read zero
  always_comb begin
    rd_word = '0;
    case (req_i.addr)
      `ANALOG_ADDR_CTRL: rd_word.ctrl.loop = loop_o;
      `ANALOG_ADDR_ADC0: rd_word = calib_word(adc_cal_o[0]);
      `ANALOG_ADDR_ADC1: rd_word = calib_word(adc_cal_o[1]);
      `ANALOG_ADDR_DAC0: rd_word = calib_word(dac_cal_o[0]);
      `ANALOG_ADDR_DAC1: rd_word = calib_word(dac_cal_o[1]);
      default: ;
    endcase
  end

  assign rdata_o = rd_word;

endmodule

//--- source/linear_calib.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module linear_calib (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  input  sample_pkg::smp_bus_t   sti_i,
  input  sample_pkg::calib_set_t cfg_i,
  output sample_pkg::smp_bus_t   sto_o
);

  localparam int unsigned CHN   = `ANALOG_CHN;
  localparam int unsigned SMP_W = `ANALOG_SMP_W;
  // full product width
  localparam int unsigned PRD_W = `ANALOG_SMP_W + `ANALOG_MUL_W;
  // fraction bits of the gain
  localparam int unsigned FRC_W = $clog2(`ANALOG_UNITY);
  // sample range limits
  localparam logic signed [PRD_W-1:0] SAT_HI = PRD_W'(2**(SMP_W-1) - 1);
  localparam logic signed [PRD_W-1:0] SAT_LO = ~SAT_HI;

  // valid per stage
  logic [1:0]                    vld_r;
  // stage 1: product and its offset
  logic signed [PRD_W-1:0]       prd_r [CHN];
  sample_pkg::sample_t [CHN-1:0] sum_r;
  // scaled plus offset, before clipping
  logic signed [PRD_W-1:0]       acc   [CHN];
  // stage 2 result
  sample_pkg::sample_t [CHN-1:0] res_r;

  // clip to sample range
  function automatic sample_pkg::sample_t sat(input logic signed [PRD_W-1:0] val);
    if (val > SAT_HI) begin
      return SAT_HI[SMP_W-1:0];
    end else if (val < SAT_LO) begin
      return SAT_LO[SMP_W-1:0];
    end
    return val[SMP_W-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // valid pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      vld_r <= '0;
    end else begin
      vld_r <= {vld_r[0], sti_i.vld};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1: multiply
  //////////////////////////////////////////////////////////////////////

  // offset travels with its product, config stays coherent per item
  always_ff @(posedge adc_clk) begin
    if (sti_i.vld) begin
      for (int i = 0; i < CHN; i++) begin
        prd_r[i] <= PRD_W'($signed(sti_i.smp[i])) * PRD_W'($signed(cfg_i[i].mul));
        sum_r[i] <= cfg_i[i].sum;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: scale, offset, saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      // drop fraction bits, sign kept
      acc[i] = (prd_r[i] >>> FRC_W) + PRD_W'($signed(sum_r[i]));
    end
  end

  always_ff @(posedge adc_clk) begin
    if (vld_r[0]) begin
      for (int i = 0; i < CHN; i++) begin
        res_r[i] <= sat(acc[i]);
      end
    end
  end

  assign sto_o = '{vld: vld_r[1], smp: res_r};

endmodule

//--- source/adc_frontend.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module adc_frontend (
  input  logic                                       adc_clk,
  input  logic                                       top_rst,
  input  logic [`ANALOG_CHN-1:0][`ANALOG_RAW_W-1:0]  adc_raw_i,
  input  logic                                       adc_vld_i,
  input  logic [`ANALOG_CHN-1:0]                     loop_i,
  input  sample_pkg::smp_bus_t                       lpb_i,
  output sample_pkg::smp_bus_t                       sto_o
);

  localparam int unsigned CHN   = `ANALOG_CHN;
  localparam int unsigned RAW_W = `ANALOG_RAW_W;
  localparam int unsigned SMP_W = `ANALOG_SMP_W;

  // selected source per channel
  logic [CHN-1:0]                src_vld;
  sample_pkg::sample_t [CHN-1:0] src_smp;
  // output register
  logic                          vld_r;
  sample_pkg::sample_t [CHN-1:0] smp_r;

  // converter format: keep msb, invert the rest
  function automatic sample_pkg::sample_t raw2smp(input logic [RAW_W-1:0] raw);
    return {raw[RAW_W-1], ~raw[RAW_W-2 -: SMP_W-1]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // loopback select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      // looped channel follows the DAC stream strobe
      src_vld[i] = loop_i[i] ? lpb_i.vld    : adc_vld_i;
      src_smp[i] = loop_i[i] ? lpb_i.smp[i] : raw2smp(adc_raw_i[i]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // any channel with fresh data raises the stream valid
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      vld_r <= 1'b0;
    end else begin
      vld_r <= |src_vld;
    end
  end

  // channel without fresh data keeps its last sample
  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < CHN; i++) begin
      if (src_vld[i]) begin
        smp_r[i] <= src_smp[i];
      end
    end
  end

  assign sto_o = '{vld: vld_r, smp: smp_r};

endmodule

//--- source/dac_backend.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module dac_backend (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  input  sample_pkg::smp_bus_t                      sti_i,
  output logic [`ANALOG_CHN-1:0][`ANALOG_SMP_W-1:0] dac_dat_o,
  output logic                                      dac_vld_o
);

  localparam int unsigned CHN   = `ANALOG_CHN;
  localparam int unsigned SMP_W = `ANALOG_SMP_W;

  // zero sample, mid-scale on the DAC
  localparam sample_pkg::sample_t SMP_ZERO = '0;

  // DAC code is offset binary with inverted slope
  // msb stays, lower bits flip
  function automatic logic [SMP_W-1:0] dac_code(input sample_pkg::sample_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_vld_o <= 1'b0;
      // idle at mid-scale until first sample
      dac_dat_o <= {CHN{dac_code(SMP_ZERO)}};
    end else begin
      dac_vld_o <= sti_i.vld;
      // between strobes the last code is held
      if (sti_i.vld) begin
        for (int i = 0; i < CHN; i++) begin
          dac_dat_o[i] <= dac_code(sti_i.smp[i]);
        end
      end
    end
  end

endmodule

//--- source/analog_top.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module analog_top (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  // ADC pins, one raw word per channel
  input  logic [`ANALOG_CHN-1:0][`ANALOG_RAW_W-1:0] adc_raw_i,
  input  logic                                      adc_vld_i,
  // generator samples
  input  sample_pkg::smp_bus_t                      gen_i,
  // register access
  input  regs_pkg::reg_req_t                        reg_req_i,
  output logic [31:0]                               reg_rdata_o,
  // calibrated acquisition stream
  output sample_pkg::smp_bus_t                      adc_o,
  // DAC pins
  output logic [`ANALOG_CHN-1:0][`ANALOG_SMP_W-1:0] dac_dat_o,
  output logic                                      dac_vld_o
);

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  // loopback enables
  logic [`ANALOG_CHN-1:0] loop;
  // calibration sets
  sample_pkg::calib_set_t adc_cfg;
  sample_pkg::calib_set_t dac_cfg;
  // front end to ADC calibration
  sample_pkg::smp_bus_t   adc_smp;
  // calibrated DAC stream, also the loopback source
  sample_pkg::smp_bus_t   dac_cal;

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  calib_regs u_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .req_i     (reg_req_i),
    .rdata_o   (reg_rdata_o),
    .loop_o    (loop),
    .adc_cal_o (adc_cfg),
    .dac_cal_o (dac_cfg)
  );

  //////////////////////////////////////////////////////////////////////
  // acquisition path, 3 cycles
  //////////////////////////////////////////////////////////////////////

  adc_frontend u_adc_fe (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_raw_i (adc_raw_i),
    .adc_vld_i (adc_vld_i),
    .loop_i    (loop),
    .lpb_i     (dac_cal),
    .sto_o     (adc_smp)
  );

  linear_calib u_adc_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .sti_i   (adc_smp),
    .cfg_i   (adc_cfg),
    .sto_o   (adc_o)
  );

  //////////////////////////////////////////////////////////////////////
  // generation path, 3 cycles
  //////////////////////////////////////////////////////////////////////

  linear_calib u_dac_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .sti_i   (gen_i),
    .cfg_i   (dac_cfg),
    .sto_o   (dac_cal)
  );

  dac_backend u_dac_be (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sti_i     (dac_cal),
    .dac_dat_o (dac_dat_o),
    .dac_vld_o (dac_vld_o)
  );

endmodule

//--- verif/analog_asserts.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module analog_asserts (
  input logic                                      adc_clk,
  input logic                                      top_rst,
  input logic [`ANALOG_CHN-1:0][`ANALOG_RAW_W-1:0] adc_raw_i,
  input logic                                      adc_vld_i,
  input sample_pkg::smp_bus_t                      gen_i,
  input regs_pkg::reg_req_t                        req_i,
  input logic [31:0]                               rdata_i,
  input sample_pkg::smp_bus_t                      adc_i,
  input logic [`ANALOG_CHN-1:0][`ANALOG_SMP_W-1:0] dac_dat_i,
  input logic                                      dac_vld_i
);

  localparam int     CHN     = `ANALOG_CHN;
  localparam longint SMP_MAX = 2**(`ANALOG_SMP_W-1) - 1;
  // converter and DAC codes flip every bit below the msb
  localparam logic [`ANALOG_SMP_W-1:0] FLIP = {1'b0, {(`ANALOG_SMP_W-1){1'b1}}};

  // failures so far, watched by the testbench
  int unsigned err_cnt = 0;
  // shadow registers
  logic [CHN-1:0]                    m_loop;
  sample_pkg::calib_set_t            m_adc;
  sample_pkg::calib_set_t            m_dac;
  logic [31:0]                       m_rdata;
  // strobe delay lines: generator, front end, per-channel fresh data
  logic [2:0]                        dv;
  logic [2:0]                        fv;
  logic [CHN-1:0]                    fr0, fr1, fr2, src_vld;
  // expected data at each model stage
  sample_pkg::sample_t [CHN-1:0]     gen_cal, dq1, dq2, src_smp, fe_smp, adc_cal, aq1, aq2;
  logic [CHN-1:0][`ANALOG_SMP_W-1:0] dcode;

  // gain with 14 fraction bits, floor shift, offset, clip
  function automatic sample_pkg::sample_t cal_ref(input sample_pkg::sample_t smp,
                                                  input sample_pkg::calib_t  cal);
    longint acc;
    acc = longint'(smp) * longint'(cal.mul);
    acc = (acc >>> 14) + longint'(cal.sum);
    if (acc > SMP_MAX) acc = SMP_MAX;
    else if (acc < -SMP_MAX - 1) acc = -SMP_MAX - 1;
    return acc[`ANALOG_SMP_W-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // shadow registers and readback
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      m_loop <= '0;
      for (int i = 0; i < CHN; i++) begin
        m_adc[i] <= '{mul: `ANALOG_UNITY, sum: '0};
        m_dac[i] <= '{mul: `ANALOG_UNITY, sum: '0};
      end
    end else if (req_i.wr) begin
      case (req_i.addr)
        `ANALOG_ADDR_CTRL: m_loop   <= req_i.wdata[CHN-1:0];
        `ANALOG_ADDR_ADC0: m_adc[0] <= '{mul: req_i.wdata[31:16], sum: req_i.wdata[13:0]};
        `ANALOG_ADDR_ADC1: m_adc[1] <= '{mul: req_i.wdata[31:16], sum: req_i.wdata[13:0]};
        `ANALOG_ADDR_DAC0: m_dac[0] <= '{mul: req_i.wdata[31:16], sum: req_i.wdata[13:0]};
        `ANALOG_ADDR_DAC1: m_dac[1] <= '{mul: req_i.wdata[31:16], sum: req_i.wdata[13:0]};
        default: ;
      endcase
    end
  end

  // reserved bits and unknown addresses read zero
  always_comb begin
    case (req_i.addr)
      `ANALOG_ADDR_CTRL: m_rdata = {{(32-CHN){1'b0}}, m_loop};
      `ANALOG_ADDR_ADC0: m_rdata = {m_adc[0].mul, 2'b00, m_adc[0].sum};
      `ANALOG_ADDR_ADC1: m_rdata = {m_adc[1].mul, 2'b00, m_adc[1].sum};
      `ANALOG_ADDR_DAC0: m_rdata = {m_dac[0].mul, 2'b00, m_dac[0].sum};
      `ANALOG_ADDR_DAC1: m_rdata = {m_dac[1].mul, 2'b00, m_dac[1].sum};
      default:           m_rdata = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // data path model
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      gen_cal[i] = cal_ref(gen_i.smp[i], m_dac[i]);
      // looped channel takes the calibrated generator stream
      src_vld[i] = m_loop[i] ? dv[1]  : adc_vld_i;
      src_smp[i] = m_loop[i] ? dq2[i] : adc_raw_i[i] ^ FLIP;
      adc_cal[i] = cal_ref(fe_smp[i], m_adc[i]);
    end
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dv  <= '0;
      fv  <= '0;
      fr0 <= '0;
      fr1 <= '0;
      fr2 <= '0;
    end else begin
      dv  <= {dv[1:0], gen_i.vld};
      fv  <= {fv[1:0], |src_vld};
      fr0 <= src_vld;
      fr1 <= fr0;
      fr2 <= fr1;
    end
  end

  // data shifts every cycle, only checked where its strobe says fresh
  always_ff @(posedge adc_clk) begin
    dq1    <= gen_cal;
    dq2    <= dq1;
    fe_smp <= src_smp;
    aq1    <= adc_cal;
    aq2    <= aq1;
    for (int i = 0; i < CHN; i++) begin
      dcode[i] <= dq2[i] ^ FLIP;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_rdata: assert property (@(posedge adc_clk) disable iff (top_rst) rdata_i == m_rdata)
    else begin
      err_cnt++;
      $error("FAILED rdata expected %h actual %h", $sampled(m_rdata), $sampled(rdata_i));
    end

  a_dac_vld: assert property (@(posedge adc_clk) disable iff (top_rst) dac_vld_i == dv[2])
    else begin
      err_cnt++;
      $error("FAILED dac_vld expected %b actual %b", $sampled(dv[2]), $sampled(dac_vld_i));
    end

  a_dac_dat: assert property (@(posedge adc_clk) disable iff (top_rst)
                              dv[2] |-> dac_dat_i == dcode)
    else begin
      err_cnt++;
      $error("FAILED dac_dat expected %h actual %h", $sampled(dcode), $sampled(dac_dat_i));
    end

  a_adc_vld: assert property (@(posedge adc_clk) disable iff (top_rst) adc_i.vld == fv[2])
    else begin
      err_cnt++;
      $error("FAILED adc_vld expected %b actual %b", $sampled(fv[2]), $sampled(adc_i.vld));
    end

  // per channel, only where that channel carried fresh data
  for (genvar c = 0; c < CHN; c++) begin : g_chn
    a_adc_smp: assert property (@(posedge adc_clk) disable iff (top_rst)
                                fr2[c] |-> adc_i.smp[c] == aq2[c])
      else begin
        err_cnt++;
        $error("FAILED adc_smp%0d expected %h actual %h", c, $sampled(aq2[c]),
               $sampled(adc_i.smp[c]));
      end
  end

endmodule

bind analog_top analog_asserts u_asserts (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .adc_raw_i (adc_raw_i),
  .adc_vld_i (adc_vld_i),
  .gen_i     (gen_i),
  .req_i     (reg_req_i),
  .rdata_i   (reg_rdata_o),
  .adc_i     (adc_o),
  .dac_dat_i (dac_dat_o),
  .dac_vld_i (dac_vld_o)
);

//--- verif/analog_tb.sv
`timescale 1ns/1ns
`include "analog_defs.svh"

module analog_tb;

  localparam int CLK_NS     = 4;
  localparam int RST_CYC    = 16;
  localparam int TRAF_CYC   = 64;
  localparam int CAL_ROUNDS = 4;
  // reset, readback, register sweep, plain traffic, calibration, loopback, drain
  localparam int RUN_CYC = RST_CYC + 16 + 34 + TRAF_CYC + CAL_ROUNDS * (10 + TRAF_CYC + 1)
                         + 3 * (2 + TRAF_CYC + 1) + 10;
  localparam int LIMIT_CYC = RUN_CYC + 200;

  integer                                          seed = 32'ha2b9_e2b9;
  logic                                            adc_clk;
  logic                                            top_rst;
  logic [`ANALOG_CHN-1:0][`ANALOG_RAW_W-1:0]       adc_raw;
  logic                                            adc_vld;
  sample_pkg::smp_bus_t                            gen;
  regs_pkg::reg_req_t                              req;
  logic [31:0]                                     rdata;
  sample_pkg::smp_bus_t                            adc_smp;
  logic [`ANALOG_CHN-1:0][`ANALOG_SMP_W-1:0]       dac_dat;
  logic                                            dac_vld;

  analog_top u_analog_top (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_raw_i   (adc_raw),
    .adc_vld_i   (adc_vld),
    .gen_i       (gen),
    .reg_req_i   (req),
    .reg_rdata_o (rdata),
    .adc_o       (adc_smp),
    .dac_dat_o   (dac_dat),
    .dac_vld_o   (dac_vld)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_NS/2) adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // random word, full scale corners a quarter of the time
  function automatic logic [`ANALOG_SMP_W-1:0] pick_word();
    int r;
    r = $random(seed);
    case (r[3:0])
      4'd0:    return 14'h1fff;
      4'd1:    return 14'h2000;
      4'd2:    return 14'h3fff;
      4'd3:    return 14'h0000;
      default: return r[31:18];
    endcase
  endfunction

  // one-cycle write strobe
  task automatic write_reg(input logic [2:0] waddr, input logic [31:0] wdata);
    @(posedge adc_clk);
    req.wr    <= 1'b1;
    req.addr  <= waddr;
    req.wdata <= wdata;
    @(posedge adc_clk);
    req.wr <= 1'b0;
  endtask

  // hold the address, the readback check runs every cycle
  task automatic read_reg(input logic [2:0] raddr);
    @(posedge adc_clk);
    req.addr <= raddr;
    @(posedge adc_clk);
  endtask

  // random strobes and samples on both streams
  task automatic traffic(input int cycles);
    int r;
    for (int n = 0; n < cycles; n++) begin
      @(posedge adc_clk);
      r = $random(seed);
      adc_vld <= r[0];
      gen.vld <= r[1];
      for (int i = 0; i < `ANALOG_CHN; i++) begin
        adc_raw[i] <= pick_word();
        gen.smp[i] <= pick_word();
      end
    end
    @(posedge adc_clk);
    adc_vld <= 1'b0;
    gen.vld <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    top_rst = 1'b1;
    adc_raw = '0;
    adc_vld = 1'b0;
    gen     = '0;
    req     = '0;
    repeat (RST_CYC) @(posedge adc_clk);
    top_rst <= 1'b0;
    // reset values at every address
    for (int a = 0; a < 8; a++) read_reg(a[2:0]);
    // unity calibration, no loopback
    traffic(TRAF_CYC);
    // random words everywhere, reserved bits must read zero
    for (int a = 0; a < 8; a++) write_reg(a[2:0], $random(seed));
    for (int a = 0; a < 8; a++) read_reg(a[2:0]);
    write_reg(`ANALOG_ADDR_CTRL, 32'h0);
    // random gains and offsets, saturation likely
    for (int k = 0; k < CAL_ROUNDS; k++) begin
      for (int a = 1; a <= 4; a++) write_reg(a[2:0], $random(seed));
      traffic(TRAF_CYC);
    end
    // channel 0 looped, channel 1 looped, then both
    for (int m = 1; m <= 3; m++) begin
      write_reg(`ANALOG_ADDR_CTRL, m);
      traffic(TRAF_CYC);
    end
    repeat (10) @(posedge adc_clk);
    if (u_analog_top.u_asserts.err_cnt != 0) begin
      $display("Done: errors found");
      $fatal(1, "assertion failures counted at end of run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

  // stop at the first failing check
  initial begin
    wait (u_analog_top.u_asserts.err_cnt != 0);
    $display("Done: errors found");
    $fatal(1, "assertion failure stopped the run");
  end

  // watchdog
  initial begin
    #(CLK_NS * LIMIT_CYC);
    $display("timeout: test sequence still running after %0d cycles", LIMIT_CYC);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- build.f
+incdir+source
source/sample_pkg.sv
source/regs_pkg.sv
source/calib_regs.sv
source/linear_calib.sv
source/adc_frontend.sv
source/dac_backend.sv
source/analog_top.sv
verif/analog_asserts.sv
verif/analog_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the analog data path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module analog_tb -o sim_analog
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_analog +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF "Done: no errors"; then
  exit 0
fi
echo "pass message not found"
exit 1
